/* verilog.f */
+incdir+.
sbox_pkg.sv
gf_power38.sv
sbox_6bit.sv
word_source.sv
word_fifo.sv
sbox_sink.sv
sbox_engine_top.sv
sbox_properties.sv
tb_sbox_engine.sv

/* Makefile */
TOP = tb_sbox_engine

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log || ! grep -q "SIMULATION PASSED" sim.log; then \
		exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module sbox_engine_top

clean:
	rm -rf obj_dir sim.log

/* tb_sbox_engine.sv */
`timescale 1ns/1ps

`include "sbox_consts.svh"

module tb_sbox_engine;
  import sbox_pkg::*;

  localparam int TIMEOUT_CYCLES = 64 * 40 + 400; // Longest run is the random stream
  localparam sbox_word_t TO_COMP [6] = '{6'b101010, 6'b010011, 6'b001110,
                                         6'b001100, 6'b100101, 6'b110000};
  localparam sbox_word_t TO_POLY [6] = '{6'b000100, 6'b011001, 6'b010110,
                                         6'b111000, 6'b010111, 6'b110011};
  localparam gf8_t LO_K [6] = '{3'd7, 3'd5, 3'd5, 3'd3, 3'd7, 3'd5};
  localparam gf8_t HI_K [6] = '{3'd5, 3'd7, 3'd3, 3'd5, 3'd5, 3'd7};

  logic       clk;
  logic       rst;
  logic       in_req;
  sbox_word_t in_data;
  logic       in_ack;
  logic       out_req;
  sbox_word_t out_data;
  logic       out_ack;

  logic [15:0] lfsr;
  int          cycles;
  int          ack_wait;
  int          checks;
  int          errors;
  int          test_errors;
  bit          sends_done;
  sbox_word_t  stim_words [$];
  int          stim_gaps [$];
  int          stim_delays [$];

  sbox_engine_top DUT (
    .clk      (clk),
    .rst      (rst),
    .in_req   (in_req),
    .in_data  (in_data),
    .in_ack   (in_ack),
    .out_req  (out_req),
    .out_data (out_data),
    .out_ack  (out_ack)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run hung and did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  function automatic gf8_t ref_mul(gf8_t a, gf8_t b);
    logic [3:0] aa;
    gf8_t       r;
    aa = {1'b0, a};
    r  = '0;
    for (int i = 0; i < 3; i++) begin
      if (b[i]) begin
        r = r ^ aa[2:0];
      end
      aa = aa << 1;
      if (aa[3]) begin
        aa = aa ^ 4'b1101; // x^3 = x^2 + 1
      end
    end
    return r;
  endfunction

  function automatic gf8_t ref_pow(gf8_t v, int n);
    gf8_t r;
    r = 3'd1;
    for (int i = 0; i < n; i++) begin
      r = ref_mul(r, v);
    end
    return r;
  endfunction

  function automatic sbox_word_t ref_sbox(sbox_word_t x);
    sbox_word_t z;
    sbox_word_t w;
    sbox_word_t p;
    gf8_t       l;
    gf8_t       h;
    gf8_t       t [6];
    for (int i = 0; i < 6; i++) begin
      z[i] = ^(x & TO_COMP[i]);
    end
    l = z[2:0];
    h = z[5:3];
    t[0] = ref_pow(l, 3);
    t[1] = ref_pow(h, 3);
    t[2] = ref_mul(ref_pow(l, 6), ref_pow(h, 4));
    t[3] = ref_mul(ref_pow(h, 6), ref_pow(l, 4));
    t[4] = ref_mul(ref_pow(l, 2), h);
    t[5] = ref_mul(ref_pow(h, 2), l);
    w = '0;
    for (int i = 0; i < 6; i++) begin
      w = w ^ {ref_mul(HI_K[i], t[i]), ref_mul(LO_K[i], t[i])};
    end
    for (int i = 0; i < 6; i++) begin
      p[i] = ^(w & TO_POLY[i]);
    end
    return p ^ {`SBOX_W{x[2] ^ x[4]}};
  endfunction

  function automatic logic lfsr_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 16'hB400;
    end
    return b;
  endfunction

  function automatic int rand_bits(int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_bit());
    end
    return v;
  endfunction

  task automatic check_word(string what, sbox_word_t got, sbox_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("Fail at %0t ns: %s got %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(string what, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_test(string name);
    $display("Test %s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "bad", test_errors);
    test_errors = 0;
  endtask

  task automatic send_word(sbox_word_t w);
    @(posedge clk);
    in_data <= w;
    in_req  <= 1'b1;
    ack_wait = 0;
    @(posedge clk);
    while (!in_ack) begin
      ack_wait++;
      @(posedge clk);
    end
    in_req <= 1'b0;
    @(posedge clk);
    while (in_ack) begin
      @(posedge clk);
    end
  endtask

  task automatic recv_word(int delay, output sbox_word_t got);
    @(posedge clk);
    while (!out_req) begin
      @(posedge clk);
    end
    got = out_data;
    repeat (delay) @(posedge clk);
    out_ack <= 1'b1;
    @(posedge clk);
    while (out_req) begin
      @(posedge clk);
    end
    out_ack <= 1'b0;
  endtask

  // Producer and consumer run side by side over the stim queues
  task automatic run_stream();
    sbox_word_t got;
    fork
      begin
        for (int i = 0; i < stim_words.size(); i++) begin
          repeat (stim_gaps[i]) @(posedge clk);
          send_word(stim_words[i]);
        end
      end
      begin
        for (int i = 0; i < stim_words.size(); i++) begin
          recv_word(stim_delays[i], got);
          check_word($sformatf("word %0d", i), got, ref_sbox(stim_words[i]));
        end
      end
    join
  endtask

  task automatic test_reset_idle();
    repeat (10) begin
      @(posedge clk);
      check_bit("in_ack", in_ack, 1'b0);
      check_bit("out_req", out_req, 1'b0);
    end
    report_test("reset idle");
  endtask

  task automatic test_single_words();
    sbox_word_t got;
    sbox_word_t words [3];
    words = '{6'd0, 6'd63, 6'd21};
    check_word("model at zero", ref_sbox('0), '0);
    foreach (words[i]) begin
      send_word(words[i]);
      recv_word(0, got);
      check_word($sformatf("single %0d", words[i]), got, ref_sbox(words[i]));
    end
    report_test("single words");
  endtask

  task automatic test_sweep();
    stim_words.delete();
    stim_gaps.delete();
    stim_delays.delete();
    for (int v = 0; v < 64; v++) begin
      stim_words.push_back(sbox_word_t'(v));
      stim_gaps.push_back(0);
      stim_delays.push_back(0);
    end
    run_stream();
    report_test("exhaustive sweep");
  endtask

  task automatic test_backpressure();
    sbox_word_t got;
    bit         stalled;
    ack_wait   = 0;
    sends_done = 1'b0;
    fork
      begin
        for (int i = 0; i < `FIFO_DEPTH + 3; i++) begin
          send_word(sbox_word_t'(i * 9 + 5));
        end
        sends_done = 1'b1;
      end
      begin
        while (ack_wait <= 20 && !sends_done) begin
          @(posedge clk);
        end
        stalled = (ack_wait > 20); // out_ack still held off here
        for (int i = 0; i < `FIFO_DEPTH + 3; i++) begin
          recv_word(0, got);
          check_word($sformatf("held word %0d", i), got, ref_sbox(sbox_word_t'(i * 9 + 5)));
        end
      end
    join
    check_bit("input stalled", stalled, 1'b1);
    report_test("back-pressure");
  endtask

  task automatic test_random();
    stim_words.delete();
    stim_gaps.delete();
    stim_delays.delete();
    for (int i = 0; i < 100; i++) begin
      stim_words.push_back(sbox_word_t'(rand_bits(6)));
      stim_gaps.push_back(rand_bits(2));
      stim_delays.push_back(rand_bits(2));
    end
    run_stream();
    report_test("random stream");
  endtask

  initial begin
    lfsr        = 16'd3232;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    rst         = 1'b1;
    in_req      = 1'b0;
    in_data     = '0;
    out_ack     = 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    test_reset_idle();
    test_single_words();
    test_sweep();
    test_backpressure();
    test_random();
    $display("Totals: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, DUT.u_props.assert_fails);
    if (errors == 0 && DUT.u_props.assert_fails == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* sbox_properties.sv */
`timescale 1ns/1ps

module sbox_properties (
  input logic                 clk,
  input logic                 rst,
  input logic                 in_req,
  input logic                 in_ack,
  input logic                 out_req,
  input sbox_pkg::sbox_word_t out_data,
  input logic                 out_ack
);

  int assert_fails = 0; // Read by the testbench at the end

  a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(in_ack) |-> $past(in_req))
    else begin
      $error("in_ack rose without in_req high");
      assert_fails++;
    end

  a_data_stable: assert property (@(posedge clk) disable iff (rst)
    (out_req && !out_ack) |=> $stable(out_data))
    else begin
      $error("out_data changed while out_req waited for out_ack");
      assert_fails++;
    end

  // Return to zero before the next word
  a_req_after_ack_low: assert property (@(posedge clk) disable iff (rst)
    $rose(out_req) |-> !$past(out_ack))
    else begin
      $error("out_req rose again before out_ack fell");
      assert_fails++;
    end

endmodule

bind sbox_engine_top sbox_properties u_props (
  .clk      (clk),
  .rst      (rst),
  .in_req   (in_req),
  .in_ack   (in_ack),
  .out_req  (out_req),
  .out_data (out_data),
  .out_ack  (out_ack)
);

/* sbox_engine_top.sv */
`timescale 1ns/1ps

`include "sbox_consts.svh"

module sbox_engine_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_req,
  input  sbox_pkg::sbox_word_t in_data,
  output logic                 in_ack,
  output logic                 out_req,
  output sbox_pkg::sbox_word_t out_data,
  input  logic                 out_ack
);
  import sbox_pkg::*;

  logic       push;
  sbox_word_t push_data;
  logic       full;
  logic       pop;
  logic       empty;
  sbox_word_t head;

  word_source u_source (
    .clk       (clk),
    .rst       (rst),
    .in_req    (in_req),
    .in_data   (in_data),
    .in_ack    (in_ack),
    .full      (full),
    .push      (push),
    .push_data (push_data)
  );

  word_fifo #(
    .T     (sbox_word_t),
    .DEPTH (`FIFO_DEPTH)
  ) u_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .head      (head),
    .full      (full),
    .empty     (empty)
  );

  sbox_sink u_sink (
    .clk      (clk),
    .rst      (rst),
    .empty    (empty),
    .head     (head),
    .pop      (pop),
    .out_req  (out_req),
    .out_data (out_data),
    .out_ack  (out_ack)
  );

endmodule

/* sbox_sink.sv */
`timescale 1ns/1ps

module sbox_sink (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 empty,
  input  sbox_pkg::sbox_word_t head,
  output logic                 pop,
  output logic                 out_req,
  output sbox_pkg::sbox_word_t out_data,
  input  logic                 out_ack
);
  import sbox_pkg::*;

  sbox_word_t sub_word;
  logic       idle;

  sbox_6bit u_sbox (
    .x (head),
    .y (sub_word)
  );

  // Handshake back at phase zero
  assign idle = !out_req && !out_ack;
  assign pop  = idle && !empty;

  always_ff @(posedge clk) begin
    if (pop) begin
      out_data <= sub_word;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_req <= 1'b0;
    end else if (pop) begin
      out_req <= 1'b1;
    end else if (out_req && out_ack) begin
      out_req <= 1'b0; // Consumer took the word
    end
  end

endmodule

/* word_fifo.sv */
`timescale 1ns/1ps

`include "sbox_consts.svh"

module word_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = `FIFO_DEPTH
) (
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  T     push_data,
  input  logic pop,
  output T     head,
  output logic full,
  output logic empty
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T                mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic            do_push;
  logic            do_pop;

  assign full    = (count == CW'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign head    = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Idle or push and pop together
      endcase
    end
  end

endmodule

/* word_source.sv */
`timescale 1ns/1ps

module word_source (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_req,
  input  sbox_pkg::sbox_word_t in_data,
  output logic                 in_ack,
  input  logic                 full,
  output logic                 push,
  output sbox_pkg::sbox_word_t push_data
);

  typedef enum logic {
    ST_IDLE,
    ST_ACK
  } state_t;

  state_t state;

  // Accept only from idle, so each request is taken once
  assign push      = (state == ST_IDLE) && in_req && !full;
  assign push_data = in_data;
  assign in_ack    = (state == ST_ACK);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (push) begin
            state <= ST_ACK; // Word is in the FIFO
          end
        end
        ST_ACK: begin
          if (!in_req) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* sbox_6bit.sv */
`timescale 1ns/1ps

module sbox_6bit (
  input  sbox_pkg::sbox_word_t x,
  output sbox_pkg::sbox_word_t y
);
  import sbox_pkg::*;

  sbox_word_t z; // Composite-field form of x
  sbox_word_t w; // z^38
  sbox_word_t p; // w back in the polynomial basis
  logic       t;

  // Basis change into GF((2^3)^2)
  assign z[0] = x[1] ^ x[3] ^ x[5];
  assign z[1] = x[0] ^ x[1] ^ x[4];
  assign z[2] = x[1] ^ x[2] ^ x[3];
  assign z[3] = x[2] ^ x[3];
  assign z[4] = x[0] ^ x[2] ^ x[5];
  assign z[5] = x[4] ^ x[5];

  gf_power38 u_pow (
    .a (z),
    .b (w)
  );

  // Inverse basis change
  assign p[0] = w[2];
  assign p[1] = w[0] ^ w[3] ^ w[4];
  assign p[2] = w[1] ^ w[2] ^ w[4];
  assign p[3] = w[3] ^ w[4] ^ w[5];
  assign p[4] = w[0] ^ w[1] ^ w[2] ^ w[4];
  assign p[5] = w[0] ^ w[1] ^ w[4] ^ w[5];

  assign t = x[2] ^ x[4]; // Affine parity term
  assign y = p ^ {$bits(sbox_word_t){t}};

endmodule

/* gf_power38.sv */
`timescale 1ns/1ps

module gf_power38 (
  input  sbox_pkg::sbox_word_t a,
  output sbox_pkg::sbox_word_t b
);
  import sbox_pkg::*;

  // Squaring is linear over GF(2)
  function automatic gf8_t gf8_sq(gf8_t v);
    return {v[1] ^ v[2], v[2], v[0] ^ v[2]};
  endfunction

  function automatic gf8_t gf8_p4(gf8_t v);
    return {v[1], v[1] ^ v[2], v[0] ^ v[1]};
  endfunction

  function automatic gf8_t gf8_p3(gf8_t v);
    return {v[1] ^ v[2] ^ (v[1] & v[2]) ^ (v[0] & v[1]),
            v[2] ^ (v[0] & v[2]) ^ (v[0] & v[1]),
            v[0] ^ v[1] ^ (v[0] & v[2])};
  endfunction

  // Square of the cube
  function automatic gf8_t gf8_p6(gf8_t v);
    return {v[1] ^ (v[1] & v[2]) ^ (v[0] & v[2]),
            v[1] ^ v[2] ^ (v[1] & v[2]) ^ (v[0] & v[1]),
            v[0] ^ v[2] ^ (v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2])};
  endfunction

  gf8_t l;
  gf8_t h;
  gf8_t t_l3;
  gf8_t t_h3;
  gf8_t t_l6h4;
  gf8_t t_h6l4;
  gf8_t t_l2h;
  gf8_t t_h2l;
  gf8_t lo;
  gf8_t hi;

  assign l = a[2:0];
  assign h = a[5:3];

  assign t_l3   = gf8_p3(l);
  assign t_h3   = gf8_p3(h);
  assign t_l6h4 = gf8_mul(gf8_p6(l), gf8_p4(h));
  assign t_h6l4 = gf8_mul(gf8_p6(h), gf8_p4(l));
  assign t_l2h  = gf8_mul(gf8_sq(l), h);
  assign t_h2l  = gf8_mul(gf8_sq(h), l);

  // Both halves mix the same six terms with swapped constants
  assign lo = gf8_mul(3'd7, t_l3)   ^ gf8_mul(3'd5, t_h3) ^
              gf8_mul(3'd5, t_l6h4) ^ gf8_mul(3'd3, t_h6l4) ^
              gf8_mul(3'd7, t_l2h)  ^ gf8_mul(3'd5, t_h2l);

  assign hi = gf8_mul(3'd5, t_l3)   ^ gf8_mul(3'd7, t_h3) ^
              gf8_mul(3'd3, t_l6h4) ^ gf8_mul(3'd5, t_h6l4) ^
              gf8_mul(3'd5, t_l2h)  ^ gf8_mul(3'd7, t_h2l);

  assign b = {hi, lo};

endmodule

/* sbox_pkg.sv */
`include "sbox_consts.svh"

package sbox_pkg;

  // Bits 2:0 low half, bits 5:3 high half in the composite basis
  typedef logic [`SBOX_W-1:0] sbox_word_t;

  typedef logic [`GF_W-1:0] gf8_t; // Element of GF(8)

  localparam logic [`GF_W:0] GF8_POLY = 4'b1101; // x^3 + x^2 + 1

  // Carry-less product of two elements, reduced by GF8_POLY
  function automatic gf8_t gf8_mul(gf8_t a, gf8_t b);
    logic [2*`GF_W-2:0] d;
    d = '0;
    for (int i = 0; i < `GF_W; i++) begin
      if (b[i]) begin
        d = d ^ ((2*`GF_W-1)'(a) << i);
      end
    end
    for (int k = 2*`GF_W-2; k >= `GF_W; k--) begin
      if (d[k]) begin
        d = d ^ ((2*`GF_W-1)'(GF8_POLY) << (k-`GF_W)); // Fold x^k back below x^3
      end
    end
    return d[`GF_W-1:0];
  endfunction

endpackage

/* sbox_consts.svh */
`ifndef SBOX_CONSTS_SVH
`define SBOX_CONSTS_SVH

// Width of one substitution word
`define SBOX_W 6

`define GF_W 3 // One GF(8) half of a word

`define FIFO_DEPTH 4 // Entries between input and output ports

`endif
